//--- design/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// cache geometry
`define DCACHE_SETS        16
`define DCACHE_WAYS        2
`define DCACHE_LINE_WORDS  4
`define DCACHE_INDEX_W     4
`define DCACHE_TAG_W       24     // 32 minus index and line offset bits

// flow control
`define DCACHE_REQ_CREDITS 2      // also depth of the stage-1 queue
`define DCACHE_MEM_CREDITS 2      // command credits granted by memory

`endif

//--- design/dcache_pkg.sv
`default_nettype none

`include "dcache_config.svh"

package dcache_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  wstrb_t;

    // lookup view of a physical address
    typedef struct packed {
        logic [`DCACHE_TAG_W-1:0]   tag;
        logic [`DCACHE_INDEX_W-1:0] index;
        logic [1:0]                 word_sel;   // word within line
        logic [1:0]                 byte_sel;
    } addr_fields_t;

    typedef union packed {
        logic [31:0]  flat;                     // bus address
        addr_fields_t f;
    } addr_u;

    typedef struct packed {
        logic                     valid;
        logic                     dirty;
        logic [`DCACHE_TAG_W-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        logic   store;
        addr_u  addr;
        word_t  wdata;
        wstrb_t wstrb;
    } cpu_req_t;

endpackage

`default_nettype wire

//--- design/mem_bus_pkg.sv
`default_nettype none

`include "dcache_config.svh"

package mem_bus_pkg;

    // word 0 sits in the low bits
    typedef logic [32*`DCACHE_LINE_WORDS-1:0] line_t;

    typedef enum logic {
        MEM_READ_LINE  = 1'b0,
        MEM_WRITE_LINE = 1'b1
    } mem_cmd_e;

endpackage

`default_nettype wire

//--- design/dcache_ifs.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_config.svh"

interface stage_if;
    import dcache_pkg::*;

    logic     valid;
    cpu_req_t req;
    logic     stall;

    modport stage1 (output valid, output req, input stall);
    modport stage2 (input valid, input req, output stall);
endinterface

interface array_if;
    import dcache_pkg::*;
    import mem_bus_pkg::*;

    logic [`DCACHE_INDEX_W-1:0]        rd_index;
    tag_entry_t [`DCACHE_WAYS-1:0]     rd_tag;
    line_t [`DCACHE_WAYS-1:0]          rd_line;
    logic                              rd_lru;     // way to evict next
    logic                              wr_en;
    logic [$clog2(`DCACHE_WAYS)-1:0]   wr_way;
    logic [`DCACHE_INDEX_W-1:0]        wr_index;
    tag_entry_t                        wr_tag;
    line_t                             wr_line;
    logic                              wr_lru;

    modport reader (output rd_index);
    modport user (input rd_tag, rd_line, rd_lru,
                  output wr_en, wr_way, wr_index, wr_tag, wr_line, wr_lru);
    modport store (input rd_index, wr_en, wr_way, wr_index, wr_tag, wr_line, wr_lru,
                   output rd_tag, rd_line, rd_lru);
endinterface

interface miss_if;
    import dcache_pkg::*;
    import mem_bus_pkg::*;

    logic  req;
    addr_u line_addr;
    logic  victim_dirty;
    addr_u victim_addr;
    line_t victim_line;
    logic  done;        // single cycle, refill valid
    line_t refill;

    modport hit (output req, line_addr, victim_dirty, victim_addr, victim_line,
                 input done, refill);
    modport miss (input req, line_addr, victim_dirty, victim_addr, victim_line,
                  output done, refill);
endinterface

`default_nettype wire

//--- design/dcache_lookup_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_config.svh"

module dcache_lookup_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 req_valid_i,
    input  dcache_pkg::cpu_req_t req_i,
    output logic                 req_credit_o,
    stage_if.stage1              stage_o,
    array_if.reader              arr_o
);
    import dcache_pkg::*;

    localparam int DEPTH = `DCACHE_REQ_CREDITS;
    localparam int PTR_W = $clog2(DEPTH);

    cpu_req_t         queue_q [DEPTH];
    cpu_req_t         head;
    cpu_req_t         req_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             valid_q;
    logic             advance;
    logic             pop;

    assign head    = queue_q[rd_ptr_q];
    assign advance = !stage_o.stall;
    assign pop     = advance && (count_q != '0);

    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            queue_q[wr_ptr_q] <= req_i;     // sender holds a credit, never full
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (req_valid_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({req_valid_i, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

    // stage-2 register
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (advance) begin
            valid_q <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            req_q <= head;
        end
    end

    // while stalled keep reading the held set
    assign arr_o.rd_index = advance ? head.addr.f.index : req_q.addr.f.index;
    assign stage_o.valid  = valid_q;
    assign stage_o.req    = req_q;
    assign req_credit_o   = pop;

endmodule

`default_nettype wire

//--- design/dcache_arrays.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_config.svh"

module dcache_arrays (
    input  logic   clk,
    input  logic   reset,
    array_if.store arr_io
);
    import dcache_pkg::*;
    import mem_bus_pkg::*;

    logic [`DCACHE_TAG_W-1:0]                 tag_mem  [`DCACHE_SETS][`DCACHE_WAYS];
    line_t                                    line_mem [`DCACHE_SETS][`DCACHE_WAYS];
    logic [`DCACHE_SETS-1:0][`DCACHE_WAYS-1:0] valid_q;
    logic [`DCACHE_SETS-1:0][`DCACHE_WAYS-1:0] dirty_q;
    logic [`DCACHE_SETS-1:0]                  lru_q;
    logic                                     same_set;

    assign same_set = arr_io.wr_en && (arr_io.wr_index == arr_io.rd_index);

    // payload storage
    always_ff @(posedge clk) begin
        if (arr_io.wr_en) begin
            tag_mem[arr_io.wr_index][arr_io.wr_way]  <= arr_io.wr_tag.tag;
            line_mem[arr_io.wr_index][arr_io.wr_way] <= arr_io.wr_line;
        end
    end

    // state bits
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else if (arr_io.wr_en) begin
            valid_q[arr_io.wr_index][arr_io.wr_way] <= arr_io.wr_tag.valid;
            dirty_q[arr_io.wr_index][arr_io.wr_way] <= arr_io.wr_tag.dirty;
            lru_q[arr_io.wr_index]                  <= arr_io.wr_lru;
        end
    end

    // synchronous read, written way forwarded
    always_ff @(posedge clk) begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (same_set && (arr_io.wr_way == w)) begin
                arr_io.rd_tag[w]  <= arr_io.wr_tag;
                arr_io.rd_line[w] <= arr_io.wr_line;
            end else begin
                arr_io.rd_tag[w] <= '{
                    valid: valid_q[arr_io.rd_index][w],
                    dirty: dirty_q[arr_io.rd_index][w],
                    tag:   tag_mem[arr_io.rd_index][w]
                };
                arr_io.rd_line[w] <= line_mem[arr_io.rd_index][w];
            end
        end
        arr_io.rd_lru <= same_set ? arr_io.wr_lru : lru_q[arr_io.rd_index];
    end

endmodule

`default_nettype wire

//--- design/dcache_hit_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_config.svh"

module dcache_hit_stage (
    input  logic              clk,
    input  logic              reset,
    stage_if.stage2           stage_i,
    array_if.user             arr_i,
    miss_if.hit               miss_o,
    output logic              resp_valid_o,
    output dcache_pkg::word_t resp_rdata_o
);
    import dcache_pkg::*;
    import mem_bus_pkg::*;

    cpu_req_t                req;
    tag_entry_t              victim_tag;
    line_t                   base_line;
    line_t                   new_line;
    logic [`DCACHE_WAYS-1:0] hit_vec;
    logic                    hit;
    logic                    hit_way;
    logic                    fill;
    logic                    miss_start;
    logic                    miss_pend_q;
    logic                    victim_q;
    logic                    acc_way;

    function automatic line_t merge_store(line_t line, cpu_req_t r);
        line_t merged;
        word_t old_w;
        word_t new_w;
        merged = line;
        old_w  = line[r.addr.f.word_sel*32 +: 32];
        for (int b = 0; b < 4; b++) begin
            new_w[b*8 +: 8] = r.wstrb[b] ? r.wdata[b*8 +: 8] : old_w[b*8 +: 8];
        end
        merged[r.addr.f.word_sel*32 +: 32] = new_w;
        return merged;
    endfunction

    assign req = stage_i.req;

    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            hit_vec[w] = arr_i.rd_tag[w].valid && (arr_i.rd_tag[w].tag == req.addr.f.tag);
        end
    end

    assign hit        = stage_i.valid && (|hit_vec);
    assign hit_way    = hit_vec[1];
    assign fill       = stage_i.valid && miss_o.done;
    assign miss_start = stage_i.valid && !hit && !miss_pend_q;
    assign victim_tag = arr_i.rd_tag[arr_i.rd_lru];

    always_ff @(posedge clk) begin
        if (reset) begin
            miss_pend_q <= 1'b0;
        end else if (miss_o.done) begin
            miss_pend_q <= 1'b0;
        end else if (miss_start) begin
            miss_pend_q <= 1'b1;
        end
    end

    // victim snapshot, held for the miss unit
    always_ff @(posedge clk) begin
        if (miss_start) begin
            victim_q                <= arr_i.rd_lru;
            miss_o.line_addr.flat   <= {req.addr.f.tag, req.addr.f.index, 4'b0000};
            miss_o.victim_addr.flat <= {victim_tag.tag, req.addr.f.index, 4'b0000};
            miss_o.victim_dirty     <= victim_tag.valid && victim_tag.dirty;
            miss_o.victim_line      <= arr_i.rd_line[arr_i.rd_lru];
        end
    end

    assign acc_way   = hit ? hit_way : victim_q;
    assign base_line = hit ? arr_i.rd_line[hit_way] : miss_o.refill;
    assign new_line  = req.store ? merge_store(base_line, req) : base_line;

    // load hits rewrite the line too, only to move LRU
    assign arr_i.wr_en    = hit || fill;
    assign arr_i.wr_way   = acc_way;
    assign arr_i.wr_index = req.addr.f.index;
    assign arr_i.wr_tag   = '{
        valid: 1'b1,
        dirty: req.store || (hit && arr_i.rd_tag[hit_way].dirty),  // keep earlier stores
        tag:   req.addr.f.tag
    };
    assign arr_i.wr_line  = new_line;
    assign arr_i.wr_lru   = ~acc_way;

    assign miss_o.req    = miss_pend_q;
    assign stage_i.stall = stage_i.valid && !hit && !miss_o.done;

    assign resp_valid_o = (hit || fill) && !req.store;
    assign resp_rdata_o = base_line[req.addr.f.word_sel*32 +: 32];

endmodule

`default_nettype wire

//--- design/dcache_miss_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_config.svh"

module dcache_miss_unit (
    input  logic                  clk,
    input  logic                  reset,
    miss_if.miss                  miss_i,
    output logic                  mem_cmd_valid_o,
    output mem_bus_pkg::mem_cmd_e mem_cmd_kind_o,
    output dcache_pkg::addr_u     mem_cmd_addr_o,
    output mem_bus_pkg::line_t    mem_cmd_data_o,
    input  logic                  mem_cmd_credit_i,
    input  logic                  mem_rsp_valid_i,
    input  mem_bus_pkg::line_t    mem_rsp_data_i
);
    import mem_bus_pkg::*;

    localparam int CRED_W = $clog2(`DCACHE_MEM_CREDITS + 1);

    typedef enum logic [1:0] {
        IDLE,
        WRITE_BACK,
        READ_REQ,
        WAIT_FILL
    } state_e;

    state_e              state_q;
    state_e              state_d;
    logic [CRED_W-1:0]   credits_q;
    logic                have_credit;
    logic                issue_wb;
    logic                issue_rd;

    assign have_credit = (credits_q != '0);

    always_comb begin
        issue_wb = 1'b0;
        issue_rd = 1'b0;
        state_d  = state_q;
        case (state_q)
            IDLE: begin
                if (miss_i.req && miss_i.victim_dirty) begin
                    issue_wb = have_credit;
                    state_d  = have_credit ? READ_REQ : WRITE_BACK;
                end else if (miss_i.req) begin
                    issue_rd = have_credit;     // clean victim, straight to read
                    state_d  = have_credit ? WAIT_FILL : READ_REQ;
                end
            end
            WRITE_BACK: begin
                issue_wb = have_credit;
                if (have_credit) state_d = READ_REQ;
            end
            READ_REQ: begin
                issue_rd = have_credit;
                if (have_credit) state_d = WAIT_FILL;
            end
            WAIT_FILL: begin
                if (mem_rsp_valid_i) state_d = IDLE;
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q   <= IDLE;
            credits_q <= CRED_W'(`DCACHE_MEM_CREDITS);
        end else begin
            state_q <= state_d;
            case ({mem_cmd_credit_i, mem_cmd_valid_o})
                2'b10:   credits_q <= credits_q + 1'b1;
                2'b01:   credits_q <= credits_q - 1'b1;
                default: ;
            endcase
        end
    end

    assign mem_cmd_valid_o = issue_wb || issue_rd;
    assign mem_cmd_kind_o  = issue_wb ? MEM_WRITE_LINE : MEM_READ_LINE;
    assign mem_cmd_addr_o  = issue_wb ? miss_i.victim_addr : miss_i.line_addr;
    assign mem_cmd_data_o  = miss_i.victim_line;     // ignored on reads

    assign miss_i.done   = (state_q == WAIT_FILL) && mem_rsp_valid_i;
    assign miss_i.refill = mem_rsp_data_i;

endmodule

`default_nettype wire

//--- design/dcache_top.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req_valid_i,
    input  logic                  req_store_i,
    input  logic [31:0]           req_addr_i,
    input  dcache_pkg::word_t     req_wdata_i,
    input  dcache_pkg::wstrb_t    req_wstrb_i,
    output logic                  req_credit_o,
    output logic                  resp_valid_o,
    output dcache_pkg::word_t     resp_rdata_o,
    output logic                  mem_cmd_valid_o,
    output mem_bus_pkg::mem_cmd_e mem_cmd_kind_o,
    output dcache_pkg::addr_u     mem_cmd_addr_o,
    output mem_bus_pkg::line_t    mem_cmd_data_o,
    input  logic                  mem_cmd_credit_i,
    input  logic                  mem_rsp_valid_i,
    input  mem_bus_pkg::line_t    mem_rsp_data_i
);
    import dcache_pkg::*;

    cpu_req_t cpu_req;

    stage_if stage_bus ();
    array_if arr_bus ();
    miss_if  miss_bus ();

    assign cpu_req = '{store: req_store_i, addr: req_addr_i,
                       wdata: req_wdata_i, wstrb: req_wstrb_i};

    dcache_lookup_stage u_lookup (
        .clk(clk), .reset(reset),
        .req_valid_i(req_valid_i), .req_i(cpu_req), .req_credit_o(req_credit_o),
        .stage_o(stage_bus.stage1), .arr_o(arr_bus.reader)
    );

    dcache_arrays u_arrays (.clk(clk), .reset(reset), .arr_io(arr_bus.store));

    dcache_hit_stage u_hit (
        .clk(clk), .reset(reset),
        .stage_i(stage_bus.stage2), .arr_i(arr_bus.user), .miss_o(miss_bus.hit),
        .resp_valid_o(resp_valid_o), .resp_rdata_o(resp_rdata_o)
    );

    dcache_miss_unit u_miss (
        .clk(clk), .reset(reset), .miss_i(miss_bus.miss),
        .mem_cmd_valid_o(mem_cmd_valid_o), .mem_cmd_kind_o(mem_cmd_kind_o),
        .mem_cmd_addr_o(mem_cmd_addr_o), .mem_cmd_data_o(mem_cmd_data_o),
        .mem_cmd_credit_i(mem_cmd_credit_i),
        .mem_rsp_valid_i(mem_rsp_valid_i), .mem_rsp_data_i(mem_rsp_data_i)
    );

endmodule

`default_nettype wire

//--- dv/dcache_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_config.svh"

module dcache_tb;
    import dcache_pkg::*;
    import mem_bus_pkg::*;

    localparam int TIMEOUT   = 2000;    // cycles allowed per wait
    localparam int MEM_WORDS = 1024;    // all test addresses sit below 4 KiB

    typedef enum logic [2:0] {OP_LD, OP_ST, OP_HOLD, OP_FREE, OP_SYNC} op_e;

    typedef struct packed {
        op_e         op;
        logic [31:0] addr;
        word_t       wdata;
        wstrb_t      wstrb;
        logic        miss;      // line read expected
        logic        wb;        // write-back expected before the read
        logic [31:0] wb_addr;
    } row_t;

    logic        clk;
    logic        reset;
    logic        req_valid_i;
    logic        req_store_i;
    logic [31:0] req_addr_i;
    word_t       req_wdata_i;
    wstrb_t      req_wstrb_i;
    logic        req_credit_o;
    logic        resp_valid_o;
    word_t       resp_rdata_o;
    logic        mem_cmd_valid_o;
    mem_cmd_e    mem_cmd_kind_o;
    addr_u       mem_cmd_addr_o;
    line_t       mem_cmd_data_o;
    logic        mem_cmd_credit_i;
    logic        mem_rsp_valid_i;
    line_t       mem_rsp_data_i;

    word_t       backing [MEM_WORDS];
    word_t       ref_mem [MEM_WORDS];
    row_t        rows [$];
    word_t       exp_resp [$];
    mem_cmd_e    exp_kind [$];
    addr_u       exp_addr [$];
    line_t       exp_line [$];
    line_t       exp_data;
    line_t       rsp_line;
    logic [31:0] lcg_state;
    logic        hold_credits;
    int          rsp_delay;     // -1 when no refill is pending
    int          owed_credits;
    int          cache_credits;
    int          req_credits;
    int          sent_count;
    int          returned_count;

    dcache_top uut (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic line_t line_from(input logic use_ref, input logic [31:0] addr);
        line_t line;
        for (int w = 0; w < `DCACHE_LINE_WORDS; w++) begin
            line[w*32 +: 32] = use_ref ? ref_mem[{addr[11:4], w[1:0]}]
                                       : backing[{addr[11:4], w[1:0]}];
        end
        return line;
    endfunction

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error: %s = 0x%h, expected 0x%h",
                                     name, got, exp));
        end
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error: %s = 0x%h, expected 0x%h",
                                     name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input addr_u got, input addr_u exp);
        if (got.flat !== exp.flat) begin
            report_failure($sformatf("** Error: %s = 0x%h, expected 0x%h",
                                     name, got.flat, exp.flat));
        end
    endtask

    task automatic check_kind(input string name, input mem_cmd_e got, input mem_cmd_e exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error: %s = 0x%h, expected 0x%h",
                                     name, got, exp));
        end
    endtask

    task automatic add_row(input op_e op, input logic [31:0] addr, input word_t wdata,
                           input wstrb_t wstrb, input logic miss, input logic wb,
                           input logic [31:0] wb_addr);
        rows.push_back('{op, addr, wdata, wstrb, miss, wb, wb_addr});
    endtask

    task automatic send_request(input logic store, input logic [31:0] addr, input word_t wdata,
                                input wstrb_t wstrb);
        int waited;
        waited = 0;
        while (req_credits == 0) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) report_failure("timeout waiting for a request credit");
        end
        req_valid_i = 1'b1;
        req_store_i = store;
        req_addr_i  = addr;
        req_wdata_i = wdata;
        req_wstrb_i = wstrb;
        req_credits--;
        sent_count++;
        @(negedge clk);
        req_valid_i = 1'b0;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (exp_resp.size() != 0 || exp_kind.size() != 0 || rsp_delay >= 0
               || owed_credits != 0 || cache_credits != `DCACHE_MEM_CREDITS) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) report_failure("timeout waiting for the cache to drain");
        end
    endtask

    task automatic apply_row(input row_t r);
        addr_u a;
        int    idx;
        idx = r.addr[11:2];
        case (r.op)
            OP_LD, OP_ST: begin
                if (r.wb) begin
                    a.flat = r.wb_addr;
                    exp_kind.push_back(MEM_WRITE_LINE);
                    exp_addr.push_back(a);
                    exp_line.push_back(line_from(1'b1, r.wb_addr));    // line as stored so far
                end
                if (r.miss) begin
                    a.flat = {r.addr[31:4], 4'b0000};
                    exp_kind.push_back(MEM_READ_LINE);
                    exp_addr.push_back(a);
                    exp_line.push_back('0);
                end
                if (r.op == OP_LD) begin
                    exp_resp.push_back(ref_mem[idx]);
                end else begin
                    for (int b = 0; b < 4; b++) begin
                        if (r.wstrb[b]) ref_mem[idx][b*8 +: 8] = r.wdata[b*8 +: 8];
                    end
                end
                send_request(r.op == OP_ST, r.addr, r.wdata, r.wstrb);
            end
            OP_HOLD: begin
                @(posedge clk);
                hold_credits = 1'b1;
                @(negedge clk);
            end
            OP_FREE: begin
                repeat (12) @(negedge clk);
                if (exp_resp.size() == 0) begin
                    report_failure("loads answered while credits were withheld");
                end
                @(posedge clk);
                hold_credits = 1'b0;
                @(negedge clk);
            end
            default: wait_idle();
        endcase
    endtask

    // processor and memory outputs as they stand before the rising edge
    always @(posedge clk) begin
        if (!reset) begin
            if (resp_valid_o) begin
                if (exp_resp.size() == 0) begin
                    report_failure("load response with no load outstanding");
                end
                check_word("resp_rdata_o", resp_rdata_o, exp_resp.pop_front());
            end
            if (req_credit_o) begin
                req_credits++;
                returned_count++;
                if (req_credits > `DCACHE_REQ_CREDITS) report_failure("too many request credits");
            end
            if (mem_rsp_valid_i) begin
                rsp_delay = -1;
            end else if (rsp_delay > 0) begin
                rsp_delay--;
            end
            if (mem_cmd_valid_o) begin
                if (cache_credits == 0) report_failure("memory command issued without a credit");
                if (exp_kind.size() == 0) begin
                    report_failure("memory command issued with none expected");
                end
                check_kind("mem_cmd_kind_o", mem_cmd_kind_o, exp_kind.pop_front());
                check_addr("mem_cmd_addr_o", mem_cmd_addr_o, exp_addr.pop_front());
                exp_data = exp_line.pop_front();
                if (mem_cmd_kind_o == MEM_WRITE_LINE) begin
                    check_line("mem_cmd_data_o", mem_cmd_data_o, exp_data);
                    for (int w = 0; w < `DCACHE_LINE_WORDS; w++) begin
                        backing[{mem_cmd_addr_o.flat[11:4], w[1:0]}] = mem_cmd_data_o[w*32 +: 32];
                    end
                end else begin
                    if (rsp_delay >= 0) begin
                        report_failure("second refill requested while one is pending");
                    end
                    lcg_state = next_random(lcg_state);
                    rsp_line  = line_from(1'b0, mem_cmd_addr_o.flat);
                    rsp_delay = 1 + int'(lcg_state[17:16]);     // 1 to 4 cycles
                end
                cache_credits--;
                owed_credits++;
            end
            if (mem_cmd_credit_i) begin
                cache_credits++;
                owed_credits--;
            end
        end
    end

    // memory model drive
    always @(negedge clk) begin
        mem_rsp_valid_i  = !reset && (rsp_delay == 0);
        mem_rsp_data_i   = rsp_line;
        mem_cmd_credit_i = !reset && !hold_credits && (owed_credits > 0);
    end

    initial begin
        clk              = 1'b0;
        reset            = 1'b1;
        req_valid_i      = 1'b0;
        req_store_i      = 1'b0;
        req_addr_i       = '0;
        req_wdata_i      = '0;
        req_wstrb_i      = '0;
        mem_cmd_credit_i = 1'b0;
        mem_rsp_valid_i  = 1'b0;
        mem_rsp_data_i   = '0;
        rsp_line         = '0;
        rsp_delay        = -1;
        hold_credits     = 1'b0;
        owed_credits     = 0;
        cache_credits    = `DCACHE_MEM_CREDITS;
        req_credits      = `DCACHE_REQ_CREDITS;
        sent_count       = 0;
        returned_count   = 0;
        lcg_state        = 32'hb064;
        for (int i = 0; i < MEM_WORDS; i++) begin
            lcg_state  = next_random(lcg_state);
            backing[i] = lcg_state;
            ref_mem[i] = lcg_state;
        end

        // set 3 holds tags 0, 1, 2
        add_row(OP_LD, 32'h034, '0, '0, 1, 0, '0);                  // cold miss
        add_row(OP_LD, 32'h038, '0, '0, 0, 0, '0);
        add_row(OP_LD, 32'h03c, '0, '0, 0, 0, '0);
        add_row(OP_ST, 32'h034, 32'ha5a5_1234, 4'b0101, 0, 0, '0);  // partial store hit
        add_row(OP_LD, 32'h034, '0, '0, 0, 0, '0);                  // right behind the store
        add_row(OP_ST, 32'h13c, 32'hdead_beef, 4'b1111, 1, 0, '0);  // store allocate
        add_row(OP_LD, 32'h138, '0, '0, 0, 0, '0);
        add_row(OP_LD, 32'h230, '0, '0, 1, 1, 32'h030);             // dirty victim in way 0
        add_row(OP_LD, 32'h034, '0, '0, 1, 1, 32'h130);             // dirty victim in way 1
        add_row(OP_LD, 32'h13c, '0, '0, 1, 0, '0);                  // clean victim
        add_row(OP_SYNC, '0, '0, '0, 0, 0, '0);
        // set 5 under withheld command credits
        add_row(OP_HOLD, '0, '0, '0, 0, 0, '0);
        add_row(OP_LD, 32'h054, '0, '0, 1, 0, '0);
        add_row(OP_LD, 32'h158, '0, '0, 1, 0, '0);
        add_row(OP_LD, 32'h250, '0, '0, 1, 0, '0);                  // no credit left
        add_row(OP_LD, 32'h254, '0, '0, 0, 0, '0);
        add_row(OP_LD, 32'h15c, '0, '0, 0, 0, '0);
        add_row(OP_FREE, '0, '0, '0, 0, 0, '0);
        add_row(OP_SYNC, '0, '0, '0, 0, 0, '0);

        repeat (3) @(negedge clk);
        reset = 1'b0;
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        wait_idle();
        if (returned_count != sent_count) begin
            report_failure($sformatf("request credits returned %0d but requests sent %0d",
                                     returned_count, sent_count));
        end else begin
            $display("Simulation completed successfully");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+design
design/dcache_pkg.sv
design/mem_bus_pkg.sv
design/dcache_ifs.sv
design/dcache_lookup_stage.sv
design/dcache_arrays.sv
design/dcache_hit_stage.sv
design/dcache_miss_unit.sv
design/dcache_top.sv
dv/dcache_tb.sv
